//--- alignment/alignment_fixer.sv
`timescale 1ns/1ps
`include "mem_align_consts.svh"

module alignment_fixer (
    input  logic                             clk,
    input  logic                             reset,
    // Head of the request FIFO
    input  logic                             fifo_valid,
    input  mem_align_pkg::mem_request_t      fifo_req,
    output logic                             fifo_pop,
    // Completion back to the decoder
    output logic                             cpl_valid,
    output mem_align_pkg::mem_completion_t   cpl,
    input  logic                             cpl_ready,
    // Word RAM
    output logic [`MEM_ADDR_W-3:0]           ram_addr,
    output logic [`MEM_DATA_W-1:0]           ram_wdata,
    output logic                             ram_we,
    input  logic [`MEM_DATA_W-1:0]           ram_rdata
);
    import mem_align_pkg::*;

    localparam int OFS_W   = $clog2(`MEM_DATA_W / 8);
    localparam int SHIFT_W = $clog2(`MEM_DATA_W);

    typedef enum logic [1:0] {
        IDLE,
        RAM_READ,
        MERGE,
        RESPOND
    } fixer_state_e;

    fixer_state_e             state;
    logic [1:0]               size_log2;
    logic [OFS_W-1:0]         align_mask;
    logic [OFS_W-1:0]         byte_offset;
    logic [SHIFT_W-1:0]       bit_shift;
    logic                     misaligned;
    logic                     word_write;
    logic [`MEM_DATA_W-1:0]   size_mask;     // Right-aligned bits of the access
    logic [`MEM_DATA_W-1:0]   lane_mask;     // Same bits at their lane
    logic [`MEM_DATA_W-1:0]   read_data;
    logic [`MEM_DATA_W-1:0]   merged_data;

    always_comb
    begin
        case (fifo_req.size)
            SIZE_BYTE:
            begin
                size_log2 = 2'd0;
                size_mask = `MEM_DATA_W'(32'h0000_00FF);
            end
            SIZE_HALF:
            begin
                size_log2 = 2'd1;
                size_mask = `MEM_DATA_W'(32'h0000_FFFF);
            end
            default:
            begin
                size_log2 = 2'd2;    // Word, also for window value 3
                size_mask = '1;
            end
        endcase
    end

    // Low address bits must be zero under the size mask
    assign align_mask  = OFS_W'((1 << size_log2) - 1);
    assign byte_offset = fifo_req.addr[OFS_W-1:0];
    assign misaligned  = |(byte_offset & align_mask);
    assign bit_shift   = {byte_offset, 3'b000};
    assign lane_mask   = size_mask << bit_shift;
    assign word_write  = (fifo_req.op == OP_WRITE) && (size_log2 == 2'd2);

    // Lane down to bit 0, zero-extended
    assign read_data   = (ram_rdata >> bit_shift) & size_mask;
    // Old bytes outside the lane, new data inside
    assign merged_data = (ram_rdata & ~lane_mask) | ((fifo_req.data & size_mask) << bit_shift);

    // Head stays put until popped, so RAM address follows it directly
    assign ram_addr  = fifo_req.addr[`MEM_ADDR_W-1:OFS_W];
    assign ram_wdata = (state == MERGE) ? merged_data : fifo_req.data;
    assign ram_we    = (state == MERGE) ||
                       ((state == IDLE) && fifo_valid && word_write && !misaligned);
    assign fifo_pop  = cpl_valid && cpl_ready;    // Done once handed over

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state     <= IDLE;
            cpl_valid <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (fifo_valid)
                    begin
                        if (misaligned || word_write)
                        begin
                            state     <= RESPOND;   // No read needed
                            cpl_valid <= 1'b1;
                        end
                        else if (fifo_req.op == OP_READ)
                            state <= RAM_READ;      // Read issued this cycle
                        else
                            state <= MERGE;         // Old word needed first
                    end
                RAM_READ, MERGE:
                begin
                    state     <= RESPOND;
                    cpl_valid <= 1'b1;
                end
                RESPOND:
                    if (cpl_ready)
                    begin
                        state     <= IDLE;
                        cpl_valid <= 1'b0;
                    end
                default:
                    state <= IDLE;
            endcase
        end
    end

    // Completion payload
    always_ff @(posedge clk)
    begin
        if (state == IDLE)
        begin
            cpl.op    <= fifo_req.op;
            cpl.error <= misaligned;
            cpl.data  <= '0;
        end
        else if (state == RAM_READ)
            cpl.data <= read_data;    // RAM data arrived
    end

endmodule

//--- common/mem_align_consts.svh
`ifndef MEM_ALIGN_CONSTS_SVH
`define MEM_ALIGN_CONSTS_SVH

// Datapath width, one RAM word
`define MEM_DATA_W 32

// Byte address into the 4 KiB RAM
`define MEM_ADDR_W 12

// Full AXI4-Lite address, byte address plus size window
`define AXI_ADDR_W 16

// Access size lives in address bits 13:12
`define SIZE_SEL_LSB 12

// Requests buffered between decoder and fixer
`define FIFO_DEPTH 4

`endif

//--- common/mem_align_pkg.sv
`include "mem_align_consts.svh"

package mem_align_pkg;

    // Log2 of the byte count, value 3 handled as a word
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } access_op_e;

    // Request from the AXI side, 47 bits
    typedef struct packed {
        access_op_e              op;
        access_size_e            size;
        logic [`MEM_ADDR_W-1:0]  addr;    // Byte address
        logic [`MEM_DATA_W-1:0]  data;    // Write data, right-aligned
    } mem_request_t;

    // Result handed back in order, 34 bits
    typedef struct packed {
        access_op_e              op;      // Steers to B or R
        logic                    error;   // Misaligned access
        logic [`MEM_DATA_W-1:0]  data;    // Read data, zero-extended
    } mem_completion_t;

endpackage

//--- design/axil_request_decoder.sv
`timescale 1ns/1ps
`include "mem_align_consts.svh"

module axil_request_decoder (
    input  logic                            clk,
    input  logic                            reset,
    // Write address and write data
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [`AXI_ADDR_W-1:0]          awaddr,
    input  logic                            wvalid,
    output logic                            wready,
    input  logic [`MEM_DATA_W-1:0]          wdata,
    input  logic [`MEM_DATA_W/8-1:0]        wstrb,     // Not used by this bus
    // Write response
    output logic                            bvalid,
    input  logic                            bready,
    output logic [1:0]                      bresp,
    // Read address and read data
    input  logic                            arvalid,
    output logic                            arready,
    input  logic [`AXI_ADDR_W-1:0]          araddr,
    output logic                            rvalid,
    input  logic                            rready,
    output logic [`MEM_DATA_W-1:0]          rdata,
    output logic [1:0]                      rresp,
    // Request towards the FIFO
    output logic                            req_valid,
    output mem_align_pkg::mem_request_t     req,
    input  logic                            req_ready,
    // Completion from the fixer
    input  logic                            cpl_valid,
    input  mem_align_pkg::mem_completion_t  cpl,
    output logic                            cpl_ready
);
    import mem_align_pkg::*;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic wr_possible;
    logic rd_possible;
    logic wr_grant;
    logic rd_grant;
    logic prefer_read;     // Arbitration toggle
    logic cpl_to_b;
    logic cpl_to_r;

    // Size window to access size, 3 counts as word
    function automatic access_size_e decode_size(input logic [1:0] window);
        case (window)
            2'd0:    return SIZE_BYTE;
            2'd1:    return SIZE_HALF;
            default: return SIZE_WORD;
        endcase
    endfunction

    // One request in flight through the readies at a time
    assign wr_possible = awvalid && wvalid && req_ready && !req_valid;
    assign rd_possible = arvalid && req_ready && !req_valid;
    assign wr_grant    = wr_possible && !(rd_possible && prefer_read);
    assign rd_grant    = rd_possible && !wr_grant;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            awready     <= 1'b0;
            wready      <= 1'b0;
            arready     <= 1'b0;
            req_valid   <= 1'b0;
            prefer_read <= 1'b0;
        end
        else
        begin
            awready   <= wr_grant;               // One-cycle pulse with wready
            wready    <= wr_grant;
            arready   <= rd_grant;
            req_valid <= wr_grant || rd_grant;   // Push lines up with handshake
            if (wr_grant)
                prefer_read <= 1'b1;             // Reads win next tie
            else if (rd_grant)
                prefer_read <= 1'b0;
        end
    end

    // Request payload captured at grant
    always_ff @(posedge clk)
    begin
        if (wr_grant)
        begin
            req.op   <= OP_WRITE;
            req.size <= decode_size(awaddr[`SIZE_SEL_LSB+1:`SIZE_SEL_LSB]);
            req.addr <= awaddr[`MEM_ADDR_W-1:0];
            req.data <= wdata;
        end
        else if (rd_grant)
        begin
            req.op   <= OP_READ;
            req.size <= decode_size(araddr[`SIZE_SEL_LSB+1:`SIZE_SEL_LSB]);
            req.addr <= araddr[`MEM_ADDR_W-1:0];
            req.data <= '0;
        end
    end

    // Take a completion when its channel is free or draining
    assign cpl_ready = (cpl.op == OP_WRITE) ? (!bvalid || bready) : (!rvalid || rready);
    assign cpl_to_b  = cpl_valid && cpl_ready && (cpl.op == OP_WRITE);
    assign cpl_to_r  = cpl_valid && cpl_ready && (cpl.op == OP_READ);

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end
        else
        begin
            if (cpl_to_b)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
            if (cpl_to_r)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // B and R holding registers
    always_ff @(posedge clk)
    begin
        if (cpl_to_b)
            bresp <= cpl.error ? RESP_SLVERR : RESP_OKAY;
        if (cpl_to_r)
        begin
            rdata <= cpl.data;
            rresp <= cpl.error ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

//--- design/mem_align_top.sv
`timescale 1ns/1ps
`include "mem_align_consts.svh"

module mem_align_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`AXI_ADDR_W-1:0]      awaddr,
    input  logic                        wvalid,
    output logic                        wready,
    input  logic [`MEM_DATA_W-1:0]      wdata,
    input  logic [`MEM_DATA_W/8-1:0]    wstrb,
    output logic                        bvalid,
    input  logic                        bready,
    output logic [1:0]                  bresp,
    input  logic                        arvalid,
    output logic                        arready,
    input  logic [`AXI_ADDR_W-1:0]      araddr,
    output logic                        rvalid,
    input  logic                        rready,
    output logic [`MEM_DATA_W-1:0]      rdata,
    output logic [1:0]                  rresp
);
    import mem_align_pkg::*;

    logic                     req_valid;
    logic                     req_ready;
    mem_request_t             req;
    logic                     fifo_full;
    logic                     fifo_empty;
    logic                     fifo_valid;
    logic                     fifo_pop;
    mem_request_t             fifo_req;
    logic                     cpl_valid;
    logic                     cpl_ready;
    mem_completion_t          cpl;
    logic [`MEM_ADDR_W-3:0]   ram_addr;
    logic [`MEM_DATA_W-1:0]   ram_wdata;
    logic                     ram_we;
    logic [`MEM_DATA_W-1:0]   ram_rdata;

    assign req_ready  = !fifo_full;
    assign fifo_valid = !fifo_empty;

    axil_request_decoder i_axil_request_decoder (
        .clk(clk), .reset(reset),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
        .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .cpl_valid(cpl_valid), .cpl(cpl), .cpl_ready(cpl_ready)
    );

    request_fifo #(.DEPTH(`FIFO_DEPTH)) i_request_fifo (
        .clk(clk), .reset(reset),
        .push(req_valid), .push_data(req), .full(fifo_full),
        .pop(fifo_pop), .pop_data(fifo_req), .empty(fifo_empty)
    );

    alignment_fixer i_alignment_fixer (
        .clk(clk), .reset(reset),
        .fifo_valid(fifo_valid), .fifo_req(fifo_req), .fifo_pop(fifo_pop),
        .cpl_valid(cpl_valid), .cpl(cpl), .cpl_ready(cpl_ready),
        .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_we(ram_we),
        .ram_rdata(ram_rdata)
    );

    word_ram i_word_ram (
        .clk(clk), .addr(ram_addr), .wdata(ram_wdata), .we(ram_we), .rdata(ram_rdata)
    );

endmodule

//--- design/request_fifo.sv
`timescale 1ns/1ps
`include "mem_align_consts.svh"

module request_fifo #(
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         push,
    input  mem_align_pkg::mem_request_t  push_data,
    output logic                         full,
    input  logic                         pop,
    output mem_align_pkg::mem_request_t  pop_data,
    output logic                         empty
);
    import mem_align_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    mem_request_t      buffer [DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;      // Items held
    logic              do_push;
    logic              do_pop;

    // Wrap also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full     = (count == CNT_W'(DEPTH));
    assign empty    = (count == '0);
    assign do_push  = push && !full;    // Overflow dropped
    assign do_pop   = pop && !empty;
    assign pop_data = buffer[rd_ptr];   // Head, valid while not empty

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            buffer[wr_ptr] <= push_data;
    end

endmodule

//--- design/word_ram.sv
`timescale 1ns/1ps
`include "mem_align_consts.svh"

module word_ram (
    input  logic                     clk,
    input  logic [`MEM_ADDR_W-3:0]   addr,     // Word index
    input  logic [`MEM_DATA_W-1:0]   wdata,
    input  logic                     we,
    output logic [`MEM_DATA_W-1:0]   rdata
);

    localparam int WORDS = 1 << (`MEM_ADDR_W - 2);

    logic [`MEM_DATA_W-1:0] mem [WORDS];

    // Read-first, old word shows on a same-address write
    always_ff @(posedge clk)
    begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];    // Registered, one cycle late
    end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_mem_align -f verilog.f -o tb_mem_align

./obj_dir/tb_mem_align > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
    echo "run_sim: PASS"
    exit 0
fi
echo "run_sim: FAIL"
exit 1

//--- verification/tb_mem_align.sv
`timescale 1ns/1ps
`include "mem_align_consts.svh"

module tb_mem_align;

    localparam int RAM_BYTES  = 1 << `MEM_ADDR_W;
    localparam int WAIT_LIMIT = 50;                  // Cycles per handshake wait

    logic                        clk;
    logic                        reset;
    logic                        awvalid;
    logic                        awready;
    logic [`AXI_ADDR_W-1:0]      awaddr;
    logic                        wvalid;
    logic                        wready;
    logic [`MEM_DATA_W-1:0]      wdata;
    logic [`MEM_DATA_W/8-1:0]    wstrb;
    logic                        bvalid;
    logic                        bready;
    logic [1:0]                  bresp;
    logic                        arvalid;
    logic                        arready;
    logic [`AXI_ADDR_W-1:0]      araddr;
    logic                        rvalid;
    logic                        rready;
    logic [`MEM_DATA_W-1:0]      rdata;
    logic [1:0]                  rresp;

    logic [7:0]                  ref_mem [RAM_BYTES];    // Byte view of the RAM
    logic [1:0]                  exp_bresp_q [$];
    logic [1:0]                  exp_rresp_q [$];
    logic [`MEM_DATA_W-1:0]      exp_rdata_q [$];
    logic [1:0]                  mon_resp;
    logic [`MEM_DATA_W-1:0]      mon_data;
    integer                      seed;

    mem_align_top i_mem_align_top (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;    // 100 ns period
    end

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input logic [`MEM_DATA_W-1:0] got,
                              input logic [`MEM_DATA_W-1:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("Mismatch at %0d ns: %s got %h, expected %h",
                                    $time, name, got, exp));
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
            stop_on_error($sformatf("Mismatch at %0d ns: %s got %0d, expected %0d",
                                    $time, name, got, exp));
    endtask

    // Bytes per access, window 3 acts as a word
    function automatic int access_bytes(input logic [1:0] window);
        case (window)
            2'd0:    return 1;
            2'd1:    return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic [1:0] expected_resp(input logic [1:0] window,
                                                 input logic [`MEM_ADDR_W-1:0] addr);
        if ((int'(addr) % access_bytes(window)) != 0)
            return 2'b10;    // SLVERR
        return 2'b00;
    endfunction

    // Little-endian gather, upper bytes stay zero
    function automatic logic [`MEM_DATA_W-1:0] expected_read(input logic [1:0] window,
                                                             input logic [`MEM_ADDR_W-1:0] addr);
        logic [`MEM_DATA_W-1:0] value;
        int                     i;
        value = '0;
        for (i = 0; i < access_bytes(window); i++)
            value[8*i +: 8] = ref_mem[(int'(addr) + i) % RAM_BYTES];
        return value;
    endfunction

    function automatic logic [`AXI_ADDR_W-1:0] axi_address(input logic [1:0] window,
                                                           input logic [`MEM_ADDR_W-1:0] addr);
        logic [`AXI_ADDR_W-1:0] full_addr;
        full_addr = `AXI_ADDR_W'(addr);
        full_addr[`SIZE_SEL_LSB +: 2] = window;    // Size window above byte address
        return full_addr;
    endfunction

    function automatic logic [`MEM_ADDR_W-1:0] align_to_word(input int value);
        return `MEM_ADDR_W'(value) & ~`MEM_ADDR_W'(3);
    endfunction

    // Misaligned writes leave the model alone
    task automatic model_write(input logic [1:0] window, input logic [`MEM_ADDR_W-1:0] addr,
                               input logic [`MEM_DATA_W-1:0] data);
        int i;
        if (expected_resp(window, addr) == 2'b00)
            for (i = 0; i < access_bytes(window); i++)
                ref_mem[int'(addr) + i] = data[8*i +: 8];
    endtask

    // Rising edge is where a transfer happens
    always @(posedge clk)
    begin
        if (reset && bvalid && bready)
        begin
            if (exp_bresp_q.size() == 0)
                stop_on_error("Write response arrived with no write outstanding");
            else
                check_resp("bresp", bresp, exp_bresp_q.pop_front());
        end
        if (reset && rvalid && rready)
        begin
            if (exp_rresp_q.size() == 0)
                stop_on_error("Read response arrived with no read outstanding");
            else
            begin
                mon_resp = exp_rresp_q.pop_front();
                mon_data = exp_rdata_q.pop_front();
                check_resp("rresp", rresp, mon_resp);
                if (mon_resp == 2'b00)
                    check_data("rdata", rdata, mon_data);    // Data undefined on SLVERR
            end
        end
    end

    task automatic write_attempt(input logic [1:0] window, input logic [`MEM_ADDR_W-1:0] addr,
                                 input logic [`MEM_DATA_W-1:0] data, input int limit,
                                 output bit accepted);
        int waited;
        waited   = 0;
        accepted = 1'b0;
        awaddr   = axi_address(window, addr);
        wdata    = data;
        awvalid  = 1'b1;
        wvalid   = 1'b1;
        while (!accepted && waited < limit)
        begin
            @(negedge clk);
            waited++;
            accepted = awready && wready;    // Transfer on the coming rising edge
        end
        if (accepted)
        begin
            exp_bresp_q.push_back(expected_resp(window, addr));
            model_write(window, addr, data);
            @(negedge clk);
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic axil_write(input logic [1:0] window, input logic [`MEM_ADDR_W-1:0] addr,
                              input logic [`MEM_DATA_W-1:0] data);
        bit accepted;
        write_attempt(window, addr, data, WAIT_LIMIT, accepted);
        if (!accepted)
            stop_on_error("Timeout waiting for awready and wready");
    endtask

    task automatic axil_read(input logic [1:0] window, input logic [`MEM_ADDR_W-1:0] addr);
        int waited;
        waited  = 0;
        araddr  = axi_address(window, addr);
        arvalid = 1'b1;
        do
        begin
            if (waited == WAIT_LIMIT)
                stop_on_error("Timeout waiting for arready");
            @(negedge clk);
            waited++;
        end
        while (!arready);
        exp_rresp_q.push_back(expected_resp(window, addr));
        exp_rdata_q.push_back(expected_read(window, addr));
        @(negedge clk);
        arvalid = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_bresp_q.size() != 0 || exp_rresp_q.size() != 0)
        begin
            if (waited == 200)
                stop_on_error("Timeout waiting for outstanding responses");
            @(negedge clk);
            waited++;
        end
    endtask

    initial
    begin
        int                       i;
        int                       lane;
        int                       count;
        bit                       accepted;
        logic [1:0]               window;
        logic [`MEM_ADDR_W-1:0]   addr;
        logic [`MEM_ADDR_W-1:0]   base;
        logic [`MEM_DATA_W-1:0]   data;

        seed    = 10;
        reset   = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '1;
        bready  = 1'b1;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b1;
        for (i = 0; i < RAM_BYTES; i++)
            ref_mem[i] = 8'h00;
        repeat (4) @(negedge clk);
        reset = 1'b1;
        @(negedge clk);

        // Every word written once, then spot reads
        for (i = 0; i < RAM_BYTES / 4; i++)
            axil_write(2'd2, `MEM_ADDR_W'(i * 4),
                       (`MEM_DATA_W'(i) * 32'h9E37_79B1) ^ 32'h5A5A_0000);
        axil_read(2'd2, '0);
        axil_read(2'd2, `MEM_ADDR_W'(RAM_BYTES - 4));
        for (i = 0; i < 64; i++)
            axil_read(2'd2, align_to_word($random(seed)));
        wait_drained();

        // Lanes of a few words, top word included
        for (i = 0; i < 4; i++)
        begin
            base = (i == 3) ? `MEM_ADDR_W'(RAM_BYTES - 4) : align_to_word($random(seed));
            for (lane = 0; lane < 4; lane++)
            begin
                axil_write(2'd0, base + `MEM_ADDR_W'(lane), $random(seed));
                axil_read(2'd2, base);    // Merged word
            end
            for (lane = 0; lane < 4; lane += 2)
            begin
                axil_write(2'd1, base + `MEM_ADDR_W'(lane), $random(seed));
                axil_read(2'd2, base);
            end
            for (lane = 0; lane < 4; lane++)
                axil_read(2'd0, base + `MEM_ADDR_W'(lane));
            for (lane = 0; lane < 4; lane += 2)
                axil_read(2'd1, base + `MEM_ADDR_W'(lane));
            // Misaligned, SLVERR and no change
            axil_write(2'd1, base + `MEM_ADDR_W'(1), $random(seed));
            axil_write(2'd1, base + `MEM_ADDR_W'(3), $random(seed));
            axil_write(2'd2, base + `MEM_ADDR_W'(2), $random(seed));
            axil_write(2'd3, base + `MEM_ADDR_W'(1), $random(seed));    // Window 3 is a word
            axil_read(2'd1, base + `MEM_ADDR_W'(3));
            axil_read(2'd2, base + `MEM_ADDR_W'(1));
            axil_read(2'd2, base);
        end
        wait_drained();

        // B held, writes pile up until awready stays low
        bready   = 1'b0;
        base     = `MEM_ADDR_W'(12'h800);
        count    = 0;
        accepted = 1'b1;
        while (accepted)
        begin
            window = (count % 4 == 0) ? 2'd2 : ((count % 4 == 1) ? 2'd0 : 2'd1);
            addr   = base + `MEM_ADDR_W'(count * 4 + count % 4);    // Last kind is misaligned
            write_attempt(window, addr, $random(seed), 20, accepted);
            if (accepted)
                count++;
            if (count > 16)
                stop_on_error("Writes still accepted while bready was held low");
        end
        if (count < `FIFO_DEPTH)
            stop_on_error("awready stayed low before the request FIFO could fill");
        bready = 1'b1;
        wait_drained();
        for (i = 0; i < count; i++)
            axil_read(2'd2, base + `MEM_ADDR_W'(i * 4));
        wait_drained();

        // Random mix, mostly aligned
        for (i = 0; i < 200; i++)
        begin
            window = 2'($random(seed));
            addr   = `MEM_ADDR_W'($random(seed));
            if (($random(seed) & 3) != 0)
                addr = addr & ~`MEM_ADDR_W'(access_bytes(window) - 1);
            data   = $random(seed);
            if ($random(seed) & 1)
                axil_write(window, addr, data);
            else
                axil_read(window, addr);
        end
        wait_drained();

        $display("Simulation passed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+common
common/mem_align_pkg.sv
design/axil_request_decoder.sv
design/request_fifo.sv
alignment/alignment_fixer.sv
design/word_ram.sv
design/mem_align_top.sv
verification/tb_mem_align.sv
